// File: flist.f
+incdir+include
hdl/ls_pkg.sv
hdl/ls_ctrl.sv
hdl/lsu.sv
hdl/csr_unit.sv
hdl/clint_timer.sv
hdl/ls_stage.sv
verification/ls_stage_tb.sv

// File: hdl/clint_timer.sv
`include "ls_macros.svh"

module clint_timer (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             we_i,
    input  logic [`XLEN-1:0] wdata_i,
    output logic [`XLEN-1:0] rdata_o,
    output logic             timer_int_o
);

    logic [`XLEN-1:0] mtime_q;
    logic [`XLEN-1:0] mtimecmp_q;
    logic             timer_int_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;          // no interrupt until programmed
            timer_int_q <= 1'b0;
        end else begin
            mtime_q     <= mtime_q + 1'b1;
            timer_int_q <= mtime_q >= mtimecmp_q;
            if (we_i) begin
                mtimecmp_q <= wdata_i;
            end
        end
    end

    assign rdata_o     = mtime_q;
    assign timer_int_o = timer_int_q;

endmodule

// File: hdl/csr_unit.sv
`include "ls_macros.svh"

module csr_unit (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             stall_n_i,
    input  logic [`XLEN-1:0] pc_i,
    input  ls_pkg::instr_u   instr_i,
    input  logic [`XLEN-1:0] wr_data_i,
    input  logic             trap_i,
    input  logic             timer_int_i,
    output logic [`XLEN-1:0] csr_data_o,
    output logic [`XLEN-1:0] mtvec_o,
    output logic [`XLEN-1:0] mepc_o,
    output logic             in_intr_ls_o
);

    localparam logic [11:0]      FUNCT12_MRET = 12'h302;
    localparam int               MIE_BIT      = 3;
    localparam int               MPIE_BIT     = 7;
    localparam int               MTI_BIT      = 7;
    localparam logic [`XLEN-1:0] CAUSE_ECALL  = 11;
    localparam logic [`XLEN-1:0] CAUSE_MTI    = {1'b1, {(`XLEN-5){1'b0}}, 4'd7};

    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] mie_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic [`XLEN-1:0] mip;
    logic [`XLEN-1:0] csr_new;
    logic [11:0]      csr_addr;
    logic             is_sys;
    logic             is_csr;
    logic             is_mret;
    logic             irq_take;

    assign csr_addr = instr_i.i_view.imm12;
    assign is_sys   = instr_i.i_view.opcode == `OP_SYSTEM;
    assign is_csr   = is_sys && instr_i.i_view.funct3[1:0] != 2'b00;
    assign is_mret  = is_sys && instr_i.i_view.funct3 == 3'b000 && csr_addr == FUNCT12_MRET;

    always_comb begin
        mip          = '0;
        mip[MTI_BIT] = timer_int_i;     // read-only pending bit
    end

    // ecall wins over a pending interrupt
    assign irq_take     = mstatus_q[MIE_BIT] && mie_q[MTI_BIT] && mip[MTI_BIT] && !trap_i;
    assign in_intr_ls_o = irq_take && stall_n_i;

    always_comb begin
        case (csr_addr)
            `CSR_MSTATUS: csr_data_o = mstatus_q;
            `CSR_MIE:     csr_data_o = mie_q;
            `CSR_MIP:     csr_data_o = mip;
            `CSR_MTVEC:   csr_data_o = mtvec_q;
            `CSR_MEPC:    csr_data_o = mepc_q;
            `CSR_MCAUSE:  csr_data_o = mcause_q;
            default:      csr_data_o = '0;
        endcase
        case (instr_i.i_view.funct3[1:0])
            2'b01:   csr_new = wr_data_i;                 // csrrw
            2'b10:   csr_new = csr_data_o | wr_data_i;    // csrrs
            2'b11:   csr_new = csr_data_o & ~wr_data_i;   // csrrc
            default: csr_new = csr_data_o;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (stall_n_i) begin
            if (trap_i || irq_take) begin
                mepc_q              <= pc_i;
                mcause_q            <= trap_i ? CAUSE_ECALL : CAUSE_MTI;
                mstatus_q[MPIE_BIT] <= mstatus_q[MIE_BIT];
                mstatus_q[MIE_BIT]  <= 1'b0;
            end else if (is_mret) begin
                mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
                mstatus_q[MPIE_BIT] <= 1'b1;
            end else if (is_csr) begin
                case (csr_addr)
                    `CSR_MSTATUS: mstatus_q <= csr_new;
                    `CSR_MIE:     mie_q     <= csr_new;
                    `CSR_MTVEC:   mtvec_q   <= csr_new;
                    `CSR_MEPC:    mepc_q    <= csr_new;
                    `CSR_MCAUSE:  mcause_q  <= csr_new;
                    default:      ;
                endcase
            end
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

    a_trap_mret: assert property (@(posedge clk) disable iff (!rst_n_i)
        trap_i |-> !is_mret)
        else $error("csr_unit: ecall trap raised on an mret");

endmodule

// File: hdl/ls_ctrl.sv
`include "ls_macros.svh"

module ls_ctrl (
    input  ls_pkg::instr_u   instr_i,
    input  ls_pkg::instr_u   instr_last_i,
    input  logic [`XLEN-1:0] addr_i,
    input  logic [`XLEN-1:0] rs2_i,
    input  logic [`XLEN-1:0] wb_data_i,
    output ls_pkg::ls_req_t  req_o
);

    localparam logic [4:0] OP_BRANCH   = 5'b11000;
    localparam logic [4:0] OP_MISC_MEM = 5'b00011;

    logic       is_32b;
    logic       is_load;
    logic       is_store;
    logic [4:0] last_op;
    logic       last_wr_rd;
    logic       fwd_hit;

    assign is_32b   = instr_i.i_view.quad == 2'b11;
    assign is_load  = is_32b && instr_i.i_view.opcode == `OP_LOAD;
    assign is_store = is_32b && instr_i.s_view.opcode == `OP_STORE;

    // everything except store, branch, fence and ecall/mret writes rd
    assign last_op    = instr_last_i.i_view.opcode;
    assign last_wr_rd = !(last_op == `OP_STORE || last_op == OP_BRANCH
                          || last_op == OP_MISC_MEM
                          || (last_op == `OP_SYSTEM
                              && instr_last_i.i_view.funct3 == 3'b000));

    assign fwd_hit = last_wr_rd && instr_last_i.i_view.rd != 5'd0
                     && instr_last_i.i_view.rd == instr_i.s_view.rs2;

    always_comb begin
        req_o.rd_en       = is_load;
        req_o.wr_en       = is_store;
        req_o.size        = instr_i.i_view.funct3[1:0];
        req_o.is_unsigned = is_load && instr_i.i_view.funct3[2];   // lbu, lhu, lwu
        req_o.to_clint    = addr_i == `CLINT_MTIMECMP || addr_i == `CLINT_MTIME;
        req_o.addr        = addr_i;
        req_o.wr_data     = (is_store && fwd_hit) ? wb_data_i : rs2_i;
    end

endmodule

// File: hdl/ls_pkg.sv
`include "ls_macros.svh"

package ls_pkg;

    typedef struct packed {
        logic [11:0] imm12;     // csr number or funct12
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  quad;      // 2'b11 for 32-bit encodings
    } i_view_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [4:0]  opcode;
        logic [1:0]  quad;
    } s_view_t;

    typedef union packed {
        i_view_t i_view;
        s_view_t s_view;
    } instr_u;

    typedef struct packed {
        logic             rd_en;
        logic             wr_en;
        logic [1:0]       size;         // log2 of bytes
        logic             is_unsigned;
        logic             to_clint;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wr_data;
    } ls_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic             rd_en;
        logic             wr_en;
        logic [`XLEN-1:0] wr_data;
        logic [7:0]       wr_mask;
        logic [2:0]       size;
    } sram_req_t;

endpackage

// File: hdl/ls_stage.sv
`include "ls_macros.svh"

module ls_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [`XLEN-1:0]  pc_i,
    input  ls_pkg::instr_u    instr_i,
    input  logic [`XLEN-1:0]  alures_i,
    input  logic [`XLEN-1:0]  rs2_i,
    input  ls_pkg::instr_u    instr_last_i,
    input  logic [`XLEN-1:0]  wb_data_i,
    input  logic              trap_ls_i,
    input  logic              stall_n_i,
    output logic [`XLEN-1:0]  ls_res_o,
    output logic [`XLEN-1:0]  csr_data_o,
    output logic [`XLEN-1:0]  mtvec_o,
    output logic [`XLEN-1:0]  mepc_o,
    output logic              ls_not_ok_o,
    output logic              in_intr_ls_o,
    output ls_pkg::sram_req_t sram_req_o,
    input  logic              sram_rd_valid_i,
    input  logic              sram_wr_ok_i,
    input  logic [`XLEN-1:0]  sram_rd_data_i
);

    ls_pkg::ls_req_t  ls_req;
    logic [`XLEN-1:0] clint_rdata;
    logic [`XLEN-1:0] clint_wdata;
    logic             clint_we;
    logic             timer_int;

    ls_ctrl ls_ctrl_u (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .addr_i       (alures_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .req_o        (ls_req)
    );

    lsu lsu_u (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stall_n_i       (stall_n_i),
        .req_i           (ls_req),
        .sram_req_o      (sram_req_o),
        .sram_rd_valid_i (sram_rd_valid_i),
        .sram_wr_ok_i    (sram_wr_ok_i),
        .sram_rd_data_i  (sram_rd_data_i),
        .clint_rdata_i   (clint_rdata),
        .clint_we_o      (clint_we),
        .clint_wdata_o   (clint_wdata),
        .ls_res_o        (ls_res_o),
        .ls_not_ok_o     (ls_not_ok_o)
    );

    csr_unit csr_unit_u (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_n_i    (stall_n_i),
        .pc_i         (pc_i),
        .instr_i      (instr_i),
        .wr_data_i    (alures_i),       // csr write value from the alu
        .trap_i       (trap_ls_i),
        .timer_int_i  (timer_int),
        .csr_data_o   (csr_data_o),
        .mtvec_o      (mtvec_o),
        .mepc_o       (mepc_o),
        .in_intr_ls_o (in_intr_ls_o)
    );

    clint_timer clint_timer_u (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .we_i        (clint_we),
        .wdata_i     (clint_wdata),
        .rdata_o     (clint_rdata),
        .timer_int_o (timer_int)
    );

endmodule

// File: hdl/lsu.sv
`include "ls_macros.svh"

module lsu (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_n_i,
    input  ls_pkg::ls_req_t   req_i,
    output ls_pkg::sram_req_t sram_req_o,
    input  logic              sram_rd_valid_i,
    input  logic              sram_wr_ok_i,
    input  logic [`XLEN-1:0]  sram_rd_data_i,
    input  logic [`XLEN-1:0]  clint_rdata_i,
    output logic              clint_we_o,
    output logic [`XLEN-1:0]  clint_wdata_o,
    output logic [`XLEN-1:0]  ls_res_o,
    output logic              ls_not_ok_o
);

    logic             done_q;
    logic             sram_acc;
    logic             clint_acc;
    logic             rd_resp;
    logic             resp;
    logic             take_res;
    logic [2:0]       offs;
    logic [7:0]       lane_mask;
    logic [`XLEN-1:0] rd_word;
    logic [`XLEN-1:0] shifted;
    logic [`XLEN-1:0] ld_val;
    logic [`XLEN-1:0] res_q;

    assign offs      = req_i.addr[2:0];
    assign sram_acc  = !req_i.to_clint && !done_q;
    assign clint_acc = req_i.to_clint && !done_q && (req_i.rd_en || req_i.wr_en);

    always_comb begin
        case (req_i.size)
            2'd0:    lane_mask = 8'h01;
            2'd1:    lane_mask = 8'h03;
            2'd2:    lane_mask = 8'h0f;
            default: lane_mask = 8'hff;
        endcase
    end

    always_comb begin
        sram_req_o.addr    = req_i.addr;
        sram_req_o.rd_en   = req_i.rd_en && sram_acc;   // held until the pulse
        sram_req_o.wr_en   = req_i.wr_en && sram_acc;
        sram_req_o.wr_mask = lane_mask << offs;
        sram_req_o.size    = {1'b0, req_i.size};
        case (req_i.size)
            2'd0:    sram_req_o.wr_data = {8{req_i.wr_data[7:0]}};
            2'd1:    sram_req_o.wr_data = {4{req_i.wr_data[15:0]}};
            2'd2:    sram_req_o.wr_data = {2{req_i.wr_data[31:0]}};
            default: sram_req_o.wr_data = req_i.wr_data;
        endcase
    end

    assign rd_resp     = sram_req_o.rd_en && sram_rd_valid_i;
    assign resp        = rd_resp || (sram_req_o.wr_en && sram_wr_ok_i);
    assign ls_not_ok_o = (sram_req_o.rd_en || sram_req_o.wr_en) && !resp;

    assign clint_we_o    = clint_acc && req_i.wr_en;
    assign clint_wdata_o = req_i.wr_data;

    assign take_res = rd_resp || (clint_acc && req_i.rd_en);
    assign rd_word  = req_i.to_clint ? clint_rdata_i : sram_rd_data_i;
    assign shifted  = rd_word >> {offs, 3'b000};

    always_comb begin
        case (req_i.size)
            2'd0: ld_val = req_i.is_unsigned ? {{(`XLEN-8){1'b0}}, shifted[7:0]}
                                             : {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
            2'd1: ld_val = req_i.is_unsigned ? {{(`XLEN-16){1'b0}}, shifted[15:0]}
                                             : {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
            2'd2: ld_val = req_i.is_unsigned ? {{(`XLEN-32){1'b0}}, shifted[31:0]}
                                             : {{(`XLEN-32){shifted[31]}}, shifted[31:0]};
            default: ld_val = shifted;
        endcase
    end

    assign ls_res_o = take_res ? ld_val : res_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else if (stall_n_i) begin
            done_q <= 1'b0;             // instruction moves on
        end else if (resp || clint_acc) begin
            done_q <= 1'b1;             // no reissue while stalled
        end
    end

    always_ff @(posedge clk) begin
        if (take_res) begin
            res_q <= ld_val;
        end
    end

    a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        sram_rd_valid_i |-> sram_req_o.rd_en)
        else $error("lsu: read valid without a pending read");

    a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        sram_wr_ok_i |-> sram_req_o.wr_en)
        else $error("lsu: write ok without a pending write");

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (sram_req_o.rd_en || sram_req_o.wr_en) && !resp |=> $stable(sram_req_o.addr))
        else $error("lsu: sram address changed during an access");

endmodule

// File: include/ls_macros.svh
`ifndef LS_MACROS_SVH
`define LS_MACROS_SVH

`define XLEN            64

// major opcodes, instr[6:2]
`define OP_LOAD         5'b00000
`define OP_STORE        5'b01000
`define OP_SYSTEM       5'b11100

`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MIP         12'h344

// timer registers, not sent to sram
`define CLINT_MTIMECMP  64'h0000_0000_0200_4000
`define CLINT_MTIME     64'h0000_0000_0200_bff8

`endif

// File: verification/ls_input.txt
// kind pc instr alures rs2 instr_last wb_data trap stall_n rdata latency exp_a exp_b
// kind 0 load 1 store 2 csr_data 3 mtvec 4 mepc 5 drive 6 irq 7 timer ld 8 timer st, lat f random
0 100 00008283 1007 0 00000013 0 0 1 8f1e2d3c4b5a6978 2 ffffffffffffff8f 0
0 104 0000c283 1007 0 00000013 0 0 1 8f1e2d3c4b5a6978 0 8f 0
0 108 00009283 1006 0 00000013 0 0 1 8f1e2d3c4b5a6978 3 ffffffffffff8f1e 0
0 10c 0000d283 1006 0 00000013 0 0 1 8f1e2d3c4b5a6978 f 8f1e 0
0 110 0000a283 1004 0 00000013 0 0 1 8f1e2d3c4b5a6978 1 ffffffff8f1e2d3c 0
0 114 0000e283 1004 0 00000013 0 0 1 8f1e2d3c4b5a6978 f 8f1e2d3c 0
0 118 0000b283 1000 0 00000013 0 0 1 8f1e2d3c4b5a6978 4 8f1e2d3c4b5a6978 0
1 11c 00608023 2005 1122334455667788 00000013 0 0 1 0 1 8888888888888888 20
1 120 00609023 2002 1234 00000313 cafe 0 1 0 2 cafecafecafecafe 0c
1 124 0060a023 2004 deadbeef01234567 0060b323 bad 0 1 0 f 0123456701234567 f0
1 128 0060b023 2000 0 00000313 0f0e0d0c0b0a0908 0 1 0 0 0f0e0d0c0b0a0908 ff
2 12c 305092f3 80001000 0 00000013 0 0 1 0 0 0 0
3 130 00000013 0 0 00000013 0 0 1 0 0 80001000 0
2 134 3050a2f3 c 0 00000013 0 0 1 0 0 80001000 0
2 138 3050b2f3 1000 0 00000013 0 0 0 0 0 8000100c 0
2 13c 3050b2f3 1000 0 00000013 0 0 1 0 0 8000100c 0
3 140 00000013 0 0 00000013 0 0 1 0 0 8000000c 0
2 144 304092f3 fff 0 00000013 0 0 1 0 0 0 0
2 148 3040b2f3 77f 0 00000013 0 0 1 0 0 fff 0
2 14c 3040a2f3 0 0 00000013 0 0 1 0 0 880 0
2 150 3000a2f3 8 0 00000013 0 0 1 0 0 0 0
5 400 00000073 0 0 00000013 0 1 1 0 0 0 0
4 154 00000013 0 0 00000013 0 0 1 0 0 400 0
2 158 3420a2f3 0 0 00000013 0 0 1 0 0 b 0
2 15c 3000a2f3 0 0 00000013 0 0 1 0 0 80 0
5 160 30200073 0 0 00000013 0 0 1 0 0 0 0
2 164 3000a2f3 0 0 00000013 0 0 1 0 0 88 0
7 168 0000b283 200bff8 0 00000013 0 0 1 0 0 0 0
8 16c 0060b023 2004000 4 00000013 0 0 1 0 0 0 0
6 800 00000013 0 0 00000013 0 0 1 0 0 800 0
2 170 3420a2f3 0 0 00000013 0 0 1 0 0 8000000000000007 0
7 174 0000b283 200bff8 0 00000013 0 0 1 0 0 0 0

// File: verification/ls_stage_tb.sv
`include "ls_macros.svh"

module ls_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 50;

    logic              clk;
    logic              rst_n_i;
    logic [`XLEN-1:0]  pc_i;
    ls_pkg::instr_u    instr_i;
    logic [`XLEN-1:0]  alures_i;
    logic [`XLEN-1:0]  rs2_i;
    ls_pkg::instr_u    instr_last_i;
    logic [`XLEN-1:0]  wb_data_i;
    logic              trap_ls_i;
    logic              stall_n_i;
    logic [`XLEN-1:0]  ls_res_o;
    logic [`XLEN-1:0]  csr_data_o;
    logic [`XLEN-1:0]  mtvec_o;
    logic [`XLEN-1:0]  mepc_o;
    logic              ls_not_ok_o;
    logic              in_intr_ls_o;
    ls_pkg::sram_req_t sram_req_o;
    logic              sram_rd_valid_i;
    logic              sram_wr_ok_i;
    logic [`XLEN-1:0]  sram_rd_data_i;

    int                errors;
    int                timeouts;
    logic [`XLEN-1:0]  last_mtime;

    // fields of the current line of the input file
    logic [3:0]        f_kind;
    logic [`XLEN-1:0]  f_pc;
    logic [31:0]       f_instr;
    logic [`XLEN-1:0]  f_alures;
    logic [`XLEN-1:0]  f_rs2;
    logic [31:0]       f_last;
    logic [`XLEN-1:0]  f_wb;
    logic              f_trap;
    logic              f_stall;
    logic [`XLEN-1:0]  f_rdata;
    logic [7:0]        f_lat;
    logic [`XLEN-1:0]  f_exp_a;
    logic [`XLEN-1:0]  f_exp_b;

    ls_stage ls_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input logic [`XLEN-1:0] act, input logic [`XLEN-1:0] exp,
                              input string what);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_sram_req(input ls_pkg::sram_req_t act, input ls_pkg::sram_req_t exp);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t ns: sram request is %h, expected %h", $time, act, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic drive_inputs();
        @(posedge clk);
        pc_i            <= f_pc;
        instr_i         <= f_instr;
        alures_i        <= f_alures;
        rs2_i           <= f_rs2;
        instr_last_i    <= f_last;
        wb_data_i       <= f_wb;
        trap_ls_i       <= f_trap;
        stall_n_i       <= f_stall;
        sram_rd_valid_i <= 1'b0;        // end of the previous pulse
        sram_wr_ok_i    <= 1'b0;
    endtask

    task automatic sram_access(input logic is_rd);
        ls_pkg::sram_req_t exp;
        int                n;
        int                lat;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(sram_req_o.rd_en || sram_req_o.wr_en) && n < TIMEOUT);
        if (!(sram_req_o.rd_en || sram_req_o.wr_en)) begin
            report_timeout("an sram enable");
            return;
        end
        check_flag(ls_not_ok_o, 1'b1, "ls_not_ok_o at request");
        if (is_rd) begin
            check_flag(sram_req_o.rd_en, 1'b1, "sram rd_en");
            check_flag(sram_req_o.wr_en, 1'b0, "sram wr_en");
            check_word(sram_req_o.addr, f_alures, "sram addr");
        end else begin
            exp.addr    = f_alures;
            exp.rd_en   = 1'b0;
            exp.wr_en   = 1'b1;
            exp.wr_data = f_exp_a;
            exp.wr_mask = f_exp_b[7:0];
            exp.size    = {1'b0, f_instr[13:12]};   // funct3 gives log2 of bytes
            check_sram_req(sram_req_o, exp);
        end
        lat = (f_lat == 8'hf) ? $urandom % 4 : f_lat;
        repeat (lat) begin
            @(negedge clk);
            check_flag(ls_not_ok_o, 1'b1, "ls_not_ok_o while waiting");
        end
        @(posedge clk);
        sram_rd_valid_i <= is_rd;
        sram_wr_ok_i    <= !is_rd;
        sram_rd_data_i  <= f_rdata;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (ls_not_ok_o && n < TIMEOUT);
        if (ls_not_ok_o) begin
            report_timeout("ls_not_ok_o to fall");
        end else if (is_rd) begin
            check_word(ls_res_o, f_exp_a, "ls_res_o");
        end
    endtask

    task automatic timer_access();
        @(negedge clk);
        check_flag(ls_not_ok_o, 1'b0, "ls_not_ok_o on a timer access");
        check_flag(sram_req_o.rd_en || sram_req_o.wr_en, 1'b0, "sram enable on a timer access");
        if (f_kind == 4'd7) begin
            // mtime counts every cycle, so each load sees a larger value
            if ($isunknown(ls_res_o) || ls_res_o <= last_mtime) begin
                errors++;
                $display("Error at %0t ns: mtime did not advance from %h to %h", $time,
                         last_mtime, ls_res_o);
            end
            last_mtime = ls_res_o;
        end
    endtask

    task automatic wait_interrupt();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check_flag(sram_req_o.rd_en || sram_req_o.wr_en, 1'b0, "sram enable before irq");
        end while (!in_intr_ls_o && n < TIMEOUT);
        if (!in_intr_ls_o) begin
            report_timeout("the timer interrupt");
        end else begin
            @(negedge clk);
            check_flag(in_intr_ls_o, 1'b0, "in_intr_ls_o a cycle after the irq");
            check_word(mepc_o, f_exp_a, "mepc_o after the irq");
        end
    endtask

    task automatic run_line();
        drive_inputs();
        case (f_kind)
            4'd0: sram_access(1'b1);
            4'd1: sram_access(1'b0);
            4'd2: begin
                @(negedge clk);
                check_word(csr_data_o, f_exp_a, "csr_data_o");
            end
            4'd3: begin
                @(negedge clk);
                check_word(mtvec_o, f_exp_a, "mtvec_o");
            end
            4'd4: begin
                @(negedge clk);
                check_word(mepc_o, f_exp_a, "mepc_o");
            end
            4'd6: wait_interrupt();
            4'd7, 4'd8: timer_access();
            default: @(negedge clk);    // drive only
        endcase
    endtask

    initial begin
        int    fd;
        int    cnt;
        string line;
        void'($urandom(32'h5e2));
        errors          = 0;
        timeouts        = 0;
        last_mtime      = '0;
        rst_n_i         = 1'b0;
        pc_i            = '0;
        instr_i         = 32'h0000_0013;    // nop
        alures_i        = '0;
        rs2_i           = '0;
        instr_last_i    = 32'h0000_0013;
        wb_data_i       = '0;
        trap_ls_i       = 1'b0;
        stall_n_i       = 1'b1;
        sram_rd_valid_i = 1'b0;
        sram_wr_ok_i    = 1'b0;
        sram_rd_data_i  = '0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_flag(sram_req_o.rd_en, 1'b0, "sram rd_en after reset");
        check_flag(sram_req_o.wr_en, 1'b0, "sram wr_en after reset");
        check_flag(ls_not_ok_o, 1'b0, "ls_not_ok_o after reset");
        check_flag(in_intr_ls_o, 1'b0, "in_intr_ls_o after reset");
        check_word(mtvec_o, '0, "mtvec_o after reset");
        check_word(mepc_o, '0, "mepc_o after reset");
        fd = $fopen("verification/ls_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open verification/ls_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f_kind, f_pc,
                              f_instr, f_alures, f_rs2, f_last, f_wb, f_trap, f_stall,
                              f_rdata, f_lat, f_exp_a, f_exp_b);
                if (cnt == 13) begin
                    run_line();
                end
            end
            $fclose(fd);
        end
        $display("%0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
